//--- src/xc_defs.svh
/*
 * Size and timing defines for the multiline correlator core.
 * Line and lag counts, counter width, sample divider, window length
 * and UART bit divider.
 */

`ifndef XC_DEFS_SVH
`define XC_DEFS_SVH

// Number of single-bit input lines sampled together.
`define XC_NUM_LINES 4

// Number of lags per line, numbered 0 to XC_NUM_LAGS-1.
`define XC_NUM_LAGS 4

// Width of each coincidence counter.
`define XC_COUNT_WIDTH 16

// System clocks between two sample strobes.
`define XC_SAMPLE_DIV 16

// Samples in one integration window.
`define XC_INTEG_SAMPLES 128

// System clocks per UART bit.
`define XC_BAUD_DIV 4

`endif

//--- src/xc_sample_pkg.sv
/*
 * Sample-side types.
 * One sample vector and the snapshot of all correlation counts.
 */

`default_nettype none

`include "xc_defs.svh"

package xc_sample_pkg;

    // One bit per input line, line 0 in bit 0.
    typedef logic [`XC_NUM_LINES-1:0] sample_t;

    // A single coincidence counter.
    typedef logic [`XC_COUNT_WIDTH-1:0] count_t;

    // All counts of one window.
    // The first index is the line and the second the lag.
    // Line 0 holds the autocorrelation, the other lines the cross-correlation
    // against line 0.
    typedef struct packed {
        count_t [`XC_NUM_LINES-1:0][`XC_NUM_LAGS-1:0] count;
    } corr_snapshot_t;

endpackage

`default_nettype wire

//--- src/xc_report_pkg.sv
/*
 * Report-side types.
 * Header layout, marker constant and the report word union.
 */

`default_nettype none

`include "xc_defs.svh"

package xc_report_pkg;

    // Every header word starts with this nibble so a receiver can find it.
    localparam logic [3:0] HEADER_MARKER = 4'hA;

    // Header word sent ahead of the counts of each line.
    // The marker sits in the top nibble, the line index in the bottom one.
    typedef struct packed {
        logic [3:0] marker;
        logic [7:0] seq;
        logic [3:0] line;
    } report_header_t;

    // One 16-bit word of a report frame.
    // The framer fills whichever view fits its position in the frame.
    // The receiver decodes a word as a header when it is at a header slot.
    typedef union packed {
        report_header_t                header;
        logic [`XC_COUNT_WIDTH-1:0]    count;
    } report_word_u;

endpackage

`default_nettype wire

//--- src/xc_sampler.sv
/*
 * Input stage.
 * Two-flop synchronizer, enable-gated sample divider, capture register.
 */

`default_nettype none

`include "xc_defs.svh"

module xc_sampler (
    input  wire                      sysclk,
    input  wire                      rst_n,
    input  wire                      enable,
    input  xc_sample_pkg::sample_t   line_in,
    output xc_sample_pkg::sample_t   sample,
    output logic                     sample_valid
);

    localparam int DIV_W = $clog2(`XC_SAMPLE_DIV);
    localparam logic [DIV_W-1:0] DIV_RELOAD = DIV_W'(`XC_SAMPLE_DIV - 1);

    xc_sample_pkg::sample_t sync_1;
    xc_sample_pkg::sample_t sync_2;
    logic [DIV_W-1:0]       div_cnt;
    logic                   strobe;

    // The lines are asynchronous to sysclk, so they pass two flops first.
    always_ff @(posedge sysclk) begin
        sync_1 <= line_in;
        sync_2 <= sync_1;
    end

    // ******************************
    // Sample divider
    // ******************************

    // The strobe fires once per XC_SAMPLE_DIV clocks while enabled.
    assign strobe = enable && (div_cnt == '0);

    // Counting down from the reload value puts the first strobe
    // exactly XC_SAMPLE_DIV clocks after enable rises.
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            div_cnt <= DIV_RELOAD;
        end else if (!enable) begin
            div_cnt <= DIV_RELOAD;
        end else if (div_cnt == '0) begin
            div_cnt <= DIV_RELOAD;
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // Capture the synchronized lines on the strobe.
    // The valid pulse lines up with the captured value.
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= strobe;
        end
        if (strobe) begin
            sample <= sync_2;
        end
    end

endmodule

`default_nettype wire

//--- src/xc_lag_correlator.sv
/*
 * Correlation stage.
 * Line-0 delay line, saturating coincidence counters, window counter
 * and the snapshot register published at the end of each window.
 */

`default_nettype none

`include "xc_defs.svh"

module xc_lag_correlator (
    input  wire                              sysclk,
    input  wire                              rst_n,
    input  xc_sample_pkg::sample_t           sample,
    input  wire                              sample_valid,
    output xc_sample_pkg::corr_snapshot_t    snapshot,
    output logic                             snapshot_valid
);

    localparam int WIN_W = $clog2(`XC_INTEG_SAMPLES);
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`XC_INTEG_SAMPLES - 1);
    localparam xc_sample_pkg::count_t COUNT_MAX = '1;

    // Past line-0 bits; bit 0 is the previous sample.
    logic [`XC_NUM_LAGS-2:0]                       hist;
    // Line-0 bit at every lag; tap 0 is the current sample.
    logic [`XC_NUM_LAGS-1:0]                       lag_taps;
    logic [`XC_NUM_LINES-1:0][`XC_NUM_LAGS-1:0]    hit;
    xc_sample_pkg::corr_snapshot_t                 acc;
    logic [WIN_W-1:0]                              win_cnt;
    logic                                          window_done;

    assign lag_taps = {hist, sample[0]};

    // ******************************
    // Coincidence detection
    // ******************************

    // A hit needs line i now and line 0 k samples ago both high.
    always_comb begin
        for (int i = 0; i < `XC_NUM_LINES; i++) begin
            for (int k = 0; k < `XC_NUM_LAGS; k++) begin
                hit[i][k] = sample[i] & lag_taps[k];
            end
        end
    end

    // ******************************
    // Counters and window
    // ******************************

    // On the cycle after the last sample, the counts restart from zero.
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            acc <= '0;
        end else begin
            for (int i = 0; i < `XC_NUM_LINES; i++) begin
                for (int k = 0; k < `XC_NUM_LAGS; k++) begin
                    if (window_done) begin
                        acc.count[i][k] <= '0;
                    end else if (sample_valid && hit[i][k] &&
                                 acc.count[i][k] != COUNT_MAX) begin
                        acc.count[i][k] <= acc.count[i][k] + 1'b1;
                    end
                end
            end
        end
    end

    // The delay line keeps running across windows.
    // Early lags of a window therefore see the tail of the previous one.
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            hist        <= '0;
            win_cnt     <= '0;
            window_done <= 1'b0;
        end else begin
            window_done <= 1'b0;
            if (sample_valid) begin
                hist <= lag_taps[`XC_NUM_LAGS-2:0];
                if (win_cnt == WIN_LAST) begin
                    win_cnt     <= '0;
                    window_done <= 1'b1;
                end else begin
                    win_cnt <= win_cnt + 1'b1;
                end
            end
        end
    end

    // Publish the finished window one cycle after its last update.
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            snapshot_valid <= 1'b0;
        end else begin
            snapshot_valid <= window_done;
        end
        if (window_done) begin
            snapshot <= acc;
        end
    end

endmodule

`default_nettype wire

//--- src/xc_report_framer.sv
/*
 * Framing stage.
 * Holds a snapshot and sends it as header and count words,
 * one word each time the transmitter is free.
 */

`default_nettype none

`include "xc_defs.svh"

module xc_report_framer (
    input  wire                              sysclk,
    input  wire                              rst_n,
    input  xc_sample_pkg::corr_snapshot_t    snapshot,
    input  wire                              snapshot_valid,
    input  wire                              tx_busy,
    output xc_report_pkg::report_word_u      word,
    output logic                             word_valid
);

    localparam int LINE_W = $clog2(`XC_NUM_LINES);
    localparam int LAG_W  = $clog2(`XC_NUM_LAGS);
    localparam logic [LINE_W-1:0] LINE_LAST = LINE_W'(`XC_NUM_LINES - 1);
    localparam logic [LAG_W-1:0]  LAG_LAST  = LAG_W'(`XC_NUM_LAGS - 1);

    xc_sample_pkg::corr_snapshot_t  snap_q;
    xc_report_pkg::report_word_u    next_word;
    logic                           busy;
    logic                           send_header;
    logic [LINE_W-1:0]              line_idx;
    logic [LAG_W-1:0]               lag_idx;
    logic [7:0]                     seq;
    logic                           take;

    // tx_busy rises only one cycle after word_valid.
    // Holding off while word_valid is high keeps words from being issued twice.
    assign take = busy && !tx_busy && !word_valid;

    // Header slot or count slot, picked by position in the frame.
    always_comb begin
        next_word = '0;
        if (send_header) begin
            next_word.header.marker = xc_report_pkg::HEADER_MARKER;
            next_word.header.seq    = seq;
            next_word.header.line   = 4'(line_idx);
        end else begin
            next_word.count = snap_q.count[line_idx][lag_idx];
        end
    end

    // ******************************
    // Frame walk
    // ******************************

    // A snapshot that shows up while busy is dropped.
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            send_header <= 1'b0;
            line_idx    <= '0;
            lag_idx     <= '0;
            seq         <= '0;
            word_valid  <= 1'b0;
        end else begin
            word_valid <= take;
            if (!busy) begin
                if (snapshot_valid) begin
                    busy        <= 1'b1;
                    send_header <= 1'b1;
                    line_idx    <= '0;
                    lag_idx     <= '0;
                end
            end else if (take) begin
                if (send_header) begin
                    send_header <= 1'b0;
                end else if (lag_idx == LAG_LAST) begin
                    lag_idx <= '0;
                    if (line_idx == LINE_LAST) begin
                        // Last word taken, so the frame is over.
                        busy <= 1'b0;
                        seq  <= seq + 1'b1;
                    end else begin
                        line_idx    <= line_idx + 1'b1;
                        send_header <= 1'b1;
                    end
                end else begin
                    lag_idx <= lag_idx + 1'b1;
                end
            end
        end
    end

    // Snapshot copy and outgoing word.
    always_ff @(posedge sysclk) begin
        if (!busy && snapshot_valid) begin
            snap_q <= snapshot;
        end
        if (take) begin
            word <= next_word;
        end
    end

endmodule

`default_nettype wire

//--- src/xc_uart_tx.sv
/*
 * Serial transmit stage.
 * Sends each 16-bit word as two 8N1 bytes, low byte first.
 */

`default_nettype none

`include "xc_defs.svh"

module xc_uart_tx (
    input  wire                           sysclk,
    input  wire                           rst_n,
    input  xc_report_pkg::report_word_u   word,
    input  wire                           word_valid,
    output logic                          tx,
    output logic                          tx_busy
);

    // Two bytes, each with a start and a stop bit.
    localparam int FRAME_BITS = 20;
    localparam int BAUD_W     = $clog2(`XC_BAUD_DIV);
    localparam int BIT_W      = $clog2(FRAME_BITS);
    localparam logic [BAUD_W-1:0] BAUD_RELOAD = BAUD_W'(`XC_BAUD_DIV - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST    = BIT_W'(FRAME_BITS - 1);

    logic [FRAME_BITS-1:0] shreg;
    logic [BAUD_W-1:0]     baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  load;
    logic                  bit_end;

    assign load    = word_valid && !tx_busy;
    assign bit_end = tx_busy && (baud_cnt == '0);

    // Line idles high between words.
    assign tx = tx_busy ? shreg[0] : 1'b1;

    // ******************************
    // Bit timing
    // ******************************

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (load) begin
            tx_busy  <= 1'b1;
            baud_cnt <= BAUD_RELOAD;
            bit_cnt  <= '0;
        end else if (bit_end) begin
            baud_cnt <= BAUD_RELOAD;
            if (bit_cnt == BIT_LAST) begin
                // Last stop bit done.
                tx_busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else if (tx_busy) begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    // The transmitter does not care which union view was filled.
    // Low byte goes in the bottom ten bits so it leaves first.
    always_ff @(posedge sysclk) begin
        if (load) begin
            shreg <= {1'b1, word[15:8], 1'b0, 1'b1, word[7:0], 1'b0};
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- src/xc_main.sv
/*
 * Correlator core top level.
 * Sampler, lag correlator, report framer and UART transmitter in a chain.
 */

`default_nettype none

module xc_main (
    input  wire                       sysclk,
    input  wire                       rst_n,
    input  wire                       enable,
    input  xc_sample_pkg::sample_t    line_in,
    output wire                       tx
);

    xc_sample_pkg::sample_t          sample;
    logic                            sample_valid;
    xc_sample_pkg::corr_snapshot_t   snapshot;
    logic                            snapshot_valid;
    xc_report_pkg::report_word_u     word;
    logic                            word_valid;
    logic                            tx_busy;

    // Lines in, one sample per strobe out.
    xc_sampler sampler_inst (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .enable         (enable),
        .line_in        (line_in),
        .sample         (sample),
        .sample_valid   (sample_valid)
    );

    // Samples in, one snapshot per window out.
    xc_lag_correlator correlator_inst (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .sample         (sample),
        .sample_valid   (sample_valid),
        .snapshot       (snapshot),
        .snapshot_valid (snapshot_valid)
    );

    // Snapshot in, report words out, paced by tx_busy.
    xc_report_framer framer_inst (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .snapshot       (snapshot),
        .snapshot_valid (snapshot_valid),
        .tx_busy        (tx_busy),
        .word           (word),
        .word_valid     (word_valid)
    );

    xc_uart_tx uart_inst (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .word           (word),
        .word_valid     (word_valid),
        .tx             (tx),
        .tx_busy        (tx_busy)
    );

endmodule

`default_nettype wire

//--- test/tb_xc_main.sv
/*
 * Testbench for the correlator core.
 * Xorshift line stimulus, reference model of the lag counts,
 * UART decoder for the report frames and typed compare tasks.
 */

`default_nettype none

`include "xc_defs.svh"

module tb_xc_main;

    localparam int WORDS_PER_FRAME = `XC_NUM_LINES * (`XC_NUM_LAGS + 1);
    localparam int NUM_FRAMES      = 4;
    // Long enough for a full window plus an enable gap and the frame latency.
    localparam int START_TIMEOUT   = 4 * `XC_SAMPLE_DIV * `XC_INTEG_SAMPLES;
    // The shortest enable gap is longer than one frame's transmit time.
    localparam int GAP_MIN         = 2000;

    logic                    sysclk;
    logic                    rst_n;
    logic                    enable;
    xc_sample_pkg::sample_t  line_in;
    wire                     tx;

    // Clocks since enable last rose, which gives the sampler's divider phase.
    int                      since_enable;
    logic [31:0]             rng_state;
    int                      frames_done;

    // Reference model state.
    xc_sample_pkg::count_t        model_count [`XC_NUM_LINES][`XC_NUM_LAGS];
    logic                         line0_past [1:`XC_NUM_LAGS-1];
    int                           model_samples;
    logic [7:0]                   model_seq;
    xc_report_pkg::report_word_u  exp_q [$];

    xc_main xc_main_inst (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .enable  (enable),
        .line_in (line_in),
        .tx      (tx)
    );

    always #5 sysclk = ~sysclk;

    // ******************************
    // Helpers
    // ******************************

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_header(input string name,
                                input xc_report_pkg::report_header_t expected,
                                input xc_report_pkg::report_header_t actual);
        if (actual !== expected) begin
            $display("error %s: expected marker %h seq %0d line %0d, %s",
                     name, expected.marker, expected.seq, expected.line,
                     $sformatf("actual marker %h seq %0d line %0d",
                               actual.marker, actual.seq, actual.line));
            abort_run();
        end
    endtask

    task automatic check_count(input string name,
                               input xc_sample_pkg::count_t expected,
                               input xc_sample_pkg::count_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // Stimulus steps land one time unit after the rising edge.
    task automatic tick();
        @(posedge sysclk);
        #1;
        since_enable++;
    endtask

    task automatic cycle_wait(input int n);
        repeat (n) begin
            @(posedge sysclk);
            #1;
        end
    endtask

    // ******************************
    // Reference model
    // ******************************

    // Queue the 20 words the DUT should send for the window just closed.
    task automatic push_expected_frame();
        xc_report_pkg::report_word_u w;
        for (int i = 0; i < `XC_NUM_LINES; i++) begin
            w = '0;
            w.header.marker = 4'hA;
            w.header.seq    = model_seq;
            w.header.line   = 4'(i);
            exp_q.push_back(w);
            for (int k = 0; k < `XC_NUM_LAGS; k++) begin
                w.count = model_count[i][k];
                exp_q.push_back(w);
                model_count[i][k] = '0;
            end
        end
        model_seq++;
        model_samples = 0;
    endtask

    // A coincidence at lag k means line i now and line 0 k samples ago.
    // The line-0 history survives the window boundary.
    task automatic model_update(input xc_sample_pkg::sample_t s);
        logic lag_bit;
        for (int i = 0; i < `XC_NUM_LINES; i++) begin
            for (int k = 0; k < `XC_NUM_LAGS; k++) begin
                lag_bit = (k == 0) ? s[0] : line0_past[k];
                if (s[i] && lag_bit && model_count[i][k] != '1) begin
                    model_count[i][k] = model_count[i][k] + 1'b1;
                end
            end
        end
        for (int k = `XC_NUM_LAGS - 1; k > 1; k--) begin
            line0_past[k] = line0_past[k-1];
        end
        line0_past[1] = s[0];
        model_samples++;
        if (model_samples == `XC_INTEG_SAMPLES) begin
            push_expected_frame();
        end
    endtask

    // ******************************
    // Stimulus
    // ******************************

    // The value set at mid-phase is what the synchronizer holds at the next strobe.
    // It is therefore sampled exactly once.
    task automatic drive_sample(input xc_sample_pkg::sample_t v);
        while (since_enable % `XC_SAMPLE_DIV != `XC_SAMPLE_DIV / 2) begin
            tick();
        end
        line_in = v;
        while (since_enable % `XC_SAMPLE_DIV != 0) begin
            tick();
        end
        model_update(v);
    endtask

    // Enable drops right after a capture edge, so no pending value is lost.
    task automatic enable_gap();
        int gap;
        rng_state = xorshift32(rng_state);
        gap = GAP_MIN + int'(rng_state % 1024);
        enable = 1'b0;
        for (int c = 0; c < gap; c++) begin
            tick();
            // The falling edge keeps this sample away from the decoder's updates.
            @(negedge sysclk);
            if (frames_done == NUM_FRAMES - 1 && tx !== 1'b1) begin
                $display("tx left idle while enable was low, %0d clocks into the gap", c);
                abort_run();
            end
        end
        if (frames_done != NUM_FRAMES - 1) begin
            $display("the frame in progress did not finish during the enable gap");
            abort_run();
        end
        tick();
        enable = 1'b1;
        since_enable = 0;
    endtask

    task automatic run_stimulus();
        for (int w = 0; w < NUM_FRAMES; w++) begin
            for (int s = 0; s < `XC_INTEG_SAMPLES; s++) begin
                // The last window is split by an enable gap at its midpoint.
                if (w == NUM_FRAMES - 1 && s == `XC_INTEG_SAMPLES / 2) begin
                    enable_gap();
                end
                rng_state = xorshift32(rng_state);
                drive_sample(rng_state[`XC_NUM_LINES-1:0]);
            end
        end
    endtask

    // ******************************
    // UART decoder
    // ******************************

    // Find the start bit, then read every bit at its middle.
    task automatic receive_byte(input int frame, input int idx, input int half,
                                output logic [7:0] data);
        int waited;
        waited = 0;
        while (tx !== 1'b0) begin
            if (waited == START_TIMEOUT) begin
                $display("timeout: byte %0d of word %0d in frame %0d never arrived",
                         half, idx, frame);
                abort_run();
            end
            cycle_wait(1);
            waited++;
        end
        cycle_wait(`XC_BAUD_DIV / 2);
        if (tx !== 1'b0) begin
            $display("framing error: start bit of word %0d in frame %0d is too short",
                     idx, frame);
            abort_run();
        end
        for (int b = 0; b < 8; b++) begin
            cycle_wait(`XC_BAUD_DIV);
            data[b] = tx;
        end
        cycle_wait(`XC_BAUD_DIV);
        if (tx !== 1'b1) begin
            $display("framing error: stop bit of word %0d in frame %0d is missing", idx, frame);
            abort_run();
        end
    endtask

    task automatic run_receiver();
        logic [7:0]                   lo;
        logic [7:0]                   hi;
        xc_report_pkg::report_word_u  got;
        xc_report_pkg::report_word_u  expected;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int i = 0; i < WORDS_PER_FRAME; i++) begin
                receive_byte(f, i, 0, lo);
                receive_byte(f, i, 1, hi);
                // Low byte leaves first.
                got = {hi, lo};
                if (exp_q.size() == 0) begin
                    $display("word %0d of frame %0d arrived before its window ended", i, f);
                    abort_run();
                end
                expected = exp_q.pop_front();
                if (i % (`XC_NUM_LAGS + 1) == 0) begin
                    check_header($sformatf("frame %0d line %0d header", f, i / 5),
                                 expected.header, got.header);
                end else begin
                    check_count($sformatf("frame %0d line %0d lag %0d", f, i / 5, i % 5 - 1),
                                expected.count, got.count);
                end
            end
            frames_done++;
        end
    endtask

    // ******************************
    // Main sequence
    // ******************************

    initial begin
        sysclk        = 1'b0;
        rst_n         = 1'b0;
        enable        = 1'b0;
        line_in       = '0;
        since_enable  = 0;
        frames_done   = 0;
        rng_state     = 32'h49ec;
        model_samples = 0;
        model_seq     = '0;
        for (int i = 0; i < `XC_NUM_LINES; i++) begin
            for (int k = 0; k < `XC_NUM_LAGS; k++) begin
                model_count[i][k] = '0;
            end
        end
        for (int k = 1; k < `XC_NUM_LAGS; k++) begin
            line0_past[k] = 1'b0;
        end

        repeat (16) @(posedge sysclk);
        #1;
        rst_n = 1'b1;
        cycle_wait(4);
        enable = 1'b1;
        since_enable = 0;

        fork
            run_stimulus();
            run_receiver();
        join

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/xc_sample_pkg.sv
src/xc_report_pkg.sv
src/xc_sampler.sv
src/xc_lag_correlator.sv
src/xc_report_framer.sv
src/xc_uart_tx.sv
src/xc_main.sv
test/tb_xc_main.sv

//--- Makefile
# Verilator build and run for the multiline correlator core.

TOP := tb_xc_main
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
